// ==== src.f ====
rtl/wbuf_bus_pkg.sv
rtl/wbuf_mem_pkg.sv
rtl/weight_sram.sv
rtl/apb_weight_port.sv
rtl/weight_buf_arbiter.sv
rtl/weight_buf_top.sv
test/tb_clk_gen.sv
test/weight_buf_chk.sv
test/weight_buf_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= src.f
TOP        ?= weight_buf_tb
RTL_TOP    ?= weight_buf_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Simulation finished: PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/weight_buf_tb.sv ====
`timescale 1ns/100ps

module weight_buf_tb;

  import wbuf_bus_pkg::*;
  import wbuf_mem_pkg::*;

  localparam int word_addr_w = 10;
  localparam int depth       = 1 << word_addr_w;
  localparam int n_rand      = 40;
  localparam int n_strb      = 12;
  localparam int n_eng       = 8;
  // about 7 cycles per host write and read pair, 6 per engine word, then a margin of four
  localparam int max_cycles  = 4 * ((n_rand + n_strb) * 7 + n_eng * 6 + 100);

  logic              clk;
  logic              rst;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  logic              eng_start;
  logic              eng_finish;
  mem_req_t          eng_req;
  logic              eng_grant;
  logic [data_w-1:0] eng_rdata;

  logic [data_w-1:0] model [int];
  int                used_idx [$];
  int                seed;
  int                checks    = 0;
  int                errors    = 0;
  int                cycle_cnt = 0;

  tb_clk_gen #(.half_period(50)) u_clk (.clk_o(clk));

  weight_buf_top #(
    .word_addr_w(word_addr_w)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .eng_start_i (eng_start),
    .eng_finish_i(eng_finish),
    .eng_req_i   (eng_req),
    .eng_grant_o (eng_grant),
    .eng_rdata_o (eng_rdata)
  );

  task automatic compare_word(input string what, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // setup cycle, then access until pready
  task automatic apb_xfer(input logic wr, input logic [31:0] addr,
      input logic [data_w-1:0] wdata, input logic [strb_w-1:0] strb,
      output logic [data_w-1:0] rdata, output logic slverr, output int cycles);
    @(negedge clk);
    apb_req        = '0;
    apb_req.psel   = 1'b1;
    apb_req.pwrite = wr;
    apb_req.paddr  = addr;
    apb_req.pwdata = wdata;
    apb_req.pstrb  = strb;
    cycles         = 1;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // sampled just before the edge that closes the cycle
    do begin
      @(posedge clk);
      cycles++;
    end while (!apb_rsp.pready);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic host_write(input int idx, input logic [data_w-1:0] data,
                            input logic [strb_w-1:0] strb);
    logic [data_w-1:0] rd;
    logic [data_w-1:0] w;
    logic              err;
    int                n;
    apb_xfer(1'b1, 32'(idx) << 2, data, strb, rd, err, n);
    compare_word("write pslverr", 32'(err), '0);
    compare_word("write cycles", n, 32'd2);
    w = model.exists(idx) ? model[idx] : '0;
    for (int b = 0; b < strb_w; b++) begin
      if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    model[idx] = w;
  endtask

  task automatic host_read_check(input int idx);
    logic [data_w-1:0] rd;
    logic              err;
    int                n;
    apb_xfer(1'b0, 32'(idx) << 2, '0, '0, rd, err, n);
    compare_word("read pslverr", 32'(err), '0);
    compare_word("read cycles", n, 32'd3);
    compare_word($sformatf("host word %0d", idx), rd, model[idx]);
  endtask

  // start or finish pulse, grant follows at the next edge
  task automatic engine_handover(input logic claim);
    @(negedge clk);
    eng_start  = claim;
    eng_finish = !claim;
    @(negedge clk);
    eng_start  = 1'b0;
    eng_finish = 1'b0;
    compare_word("grant after handover", 32'(eng_grant), 32'(claim));
  endtask

  task automatic engine_access(input logic we, input int idx, input logic [data_w-1:0] data);
    @(negedge clk);
    eng_req       = '0;
    eng_req.cs    = 1'b1;
    eng_req.we    = we;
    eng_req.be    = '1;
    eng_req.addr  = 16'(idx);
    eng_req.wdata = data;
    @(negedge clk);
    eng_req = '0;
    if (we) model[idx] = data;
    else compare_word($sformatf("engine word %0d", idx), eng_rdata, model[idx]);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: the tests did not end within %0d cycles", max_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    logic [data_w-1:0] rd;
    logic              err;
    int                n;
    int                idx;

    seed       = 24;
    rst        = 1'b1;
    apb_req    = '0;
    eng_start  = 1'b0;
    eng_finish = 1'b0;
    eng_req    = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < n_rand; i++) begin
      idx = $unsigned($random(seed)) % depth;
      used_idx.push_back(idx);
      host_write(idx, $random(seed), '1);
    end
    foreach (used_idx[i]) host_read_check(used_idx[i]);

    // partial strobes only on words with known contents
    for (int i = 0; i < n_strb; i++) begin
      idx = used_idx[$unsigned($random(seed)) % used_idx.size()];
      host_write(idx, $random(seed), 4'($random(seed)));
      host_read_check(idx);
    end

    // index 1024 aliases word 0 in the low address bits
    host_write(0, 32'h1357_9bdf, '1);
    apb_xfer(1'b1, 32'(depth) << 2, 32'hdead_beef, '1, rd, err, n);
    compare_word("range write pslverr", 32'(err), 32'd1);
    compare_word("range write cycles", n, 32'd2);
    apb_xfer(1'b0, 32'h0001_0004, '0, '0, rd, err, n);
    compare_word("range read pslverr", 32'(err), 32'd1);
    compare_word("range read prdata", rd, '0);
    host_read_check(0);

    engine_handover(1'b1);
    for (int i = 0; i < n_eng; i++) engine_access(1'b1, used_idx[i], $random(seed));
    for (int i = 0; i < n_eng; i++) engine_access(1'b0, used_idx[i], '0);
    engine_handover(1'b0);
    for (int i = 0; i < n_eng; i++) host_read_check(used_idx[i]);

    idx = used_idx[n_eng];
    engine_handover(1'b1);
    apb_xfer(1'b1, 32'(idx) << 2, ~model[idx], '1, rd, err, n);
    compare_word("denied write pslverr", 32'(err), 32'd1);
    engine_handover(1'b0);
    host_read_check(idx);

    // start pulse lands in the first access cycle of a host read
    fork
      host_read_check(used_idx[n_eng + 1]);
      begin
        repeat (2) @(negedge clk);
        eng_start = 1'b1;
        @(negedge clk);
        eng_start = 1'b0;
      end
    join
    compare_word("grant at end of host read", 32'(eng_grant), '0);
    for (n = 0; n < 4 && !eng_grant; n++) @(negedge clk);
    compare_word("deferred grant", 32'(eng_grant), 32'd1);
    engine_handover(1'b0);

    $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
             checks, errors, dut0.chk0.fail_count);
    if (errors == 0 && dut0.chk0.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== test/weight_buf_chk.sv ====
`timescale 1ns/100ps

module weight_buf_chk (
  input logic                   clk,
  input logic                   rst,
  input wbuf_bus_pkg::apb_req_t apb_req_i,
  input wbuf_bus_pkg::apb_rsp_t apb_rsp_i,
  input logic                   host_busy_i,
  input logic                   host_denied_i,
  input logic                   eng_grant_i,
  input wbuf_mem_pkg::mem_req_t eng_req_i,
  input wbuf_mem_pkg::mem_req_t sram_req_i
);

  int fail_count = 0;

  pready_in_access: assert property (@(posedge clk) disable iff (rst)
      apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable)
    else begin
      $error("pready seen outside an APB access phase");
      fail_count++;
    end

  // the engine is never granted while a host transfer is in flight
  grant_after_host: assert property (@(posedge clk) disable iff (rst)
      $rose(eng_grant_i) |-> !$past(host_busy_i))
    else begin
      $error("engine grant rose during a host transfer");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk)
      rst |-> !apb_rsp_i.pready && !eng_grant_i && !(sram_req_i.cs && sram_req_i.we))
    else begin
      $error("pready, grant or SRAM write active during reset");
      fail_count++;
    end

  // every SRAM write comes from the engine or from an accepted host write
  write_has_source: assert property (@(posedge clk) disable iff (rst)
      sram_req_i.cs && sram_req_i.we |-> (eng_grant_i && eng_req_i.cs && eng_req_i.we)
        || (apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && !host_denied_i))
    else begin
      $error("SRAM write without a matching engine or host write");
      fail_count++;
    end

endmodule

bind weight_buf_top weight_buf_chk chk0 (
  .clk          (clk),
  .rst          (rst),
  .apb_req_i    (apb_req_i),
  .apb_rsp_i    (apb_rsp_o),
  .host_busy_i  (host_busy),
  .host_denied_i(host_denied),
  .eng_grant_i  (eng_grant_o),
  .eng_req_i    (eng_req_i),
  .sram_req_i   (sram_req)
);

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int half_period = 50
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

endmodule

// ==== rtl/weight_buf_top.sv ====
`timescale 1ns/100ps

module weight_buf_top #(
  parameter int word_addr_w = 10
) (
  input  logic                            clk,
  input  logic                            rst,
  input  wbuf_bus_pkg::apb_req_t          apb_req_i,
  output wbuf_bus_pkg::apb_rsp_t          apb_rsp_o,
  input  logic                            eng_start_i,
  input  logic                            eng_finish_i,
  input  wbuf_mem_pkg::mem_req_t          eng_req_i,
  output logic                            eng_grant_o,
  output logic [wbuf_bus_pkg::data_w-1:0] eng_rdata_o
);

  import wbuf_bus_pkg::*;
  import wbuf_mem_pkg::*;

  mem_req_t          host_req;
  mem_req_t          sram_req;
  logic              host_busy;
  logic              host_denied;
  logic [data_w-1:0] host_rdata;

  apb_weight_port #(
    .word_addr_w(word_addr_w)
  ) u_apb_port (
    .clk          (clk),
    .rst          (rst),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .host_req_o   (host_req),
    .host_busy_o  (host_busy),
    .host_rdata_i (host_rdata),
    .host_denied_i(host_denied)
  );

  // sram_req is the request seen by the storage array
  weight_buf_arbiter #(
    .word_addr_w(word_addr_w)
  ) u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .host_req_i   (host_req),
    .host_busy_i  (host_busy),
    .host_rdata_o (host_rdata),
    .host_denied_o(host_denied),
    .eng_start_i  (eng_start_i),
    .eng_finish_i (eng_finish_i),
    .eng_req_i    (eng_req_i),
    .eng_grant_o  (eng_grant_o),
    .eng_rdata_o  (eng_rdata_o),
    .sram_req_o   (sram_req)
  );

endmodule

// ==== rtl/weight_buf_arbiter.sv ====
`timescale 1ns/100ps

module weight_buf_arbiter #(
  parameter int word_addr_w = 10
) (
  input  logic                            clk,
  input  logic                            rst,
  input  wbuf_mem_pkg::mem_req_t          host_req_i,
  input  logic                            host_busy_i,
  output logic [wbuf_bus_pkg::data_w-1:0] host_rdata_o,
  output logic                            host_denied_o,
  input  logic                            eng_start_i,
  input  logic                            eng_finish_i,
  input  wbuf_mem_pkg::mem_req_t          eng_req_i,
  output logic                            eng_grant_o,
  output logic [wbuf_bus_pkg::data_w-1:0] eng_rdata_o,
  output wbuf_mem_pkg::mem_req_t          sram_req_o
);

  import wbuf_bus_pkg::*;
  import wbuf_mem_pkg::*;

  buf_owner_e        owner_q, owner_d;
  buf_owner_e        rd_sel_q;
  logic              pending_q, pending_d;
  logic              start_req;
  logic [data_w-1:0] sram_rdata;

  weight_sram #(
    .word_addr_w(word_addr_w)
  ) u_sram (
    .clk      (clk),
    .rst      (rst),
    .mem_req_i(sram_req_o),
    .rdata_o  (sram_rdata)
  );

  // a start seen while the host is busy is kept until it can be served
  assign start_req = eng_start_i || pending_q;

  always_comb begin
    owner_d = owner_q;
    case (owner_q)
      owner_none: begin
        if (host_busy_i) begin
          owner_d = owner_host;
        end else if (start_req) begin
          owner_d = owner_engine;
        end
      end
      owner_host: begin
        if (!host_busy_i) begin
          owner_d = start_req ? owner_engine : owner_none;
        end
      end
      owner_engine: begin
        if (eng_finish_i) begin
          owner_d = owner_none;
        end
      end
      default: owner_d = owner_none;
    endcase
  end

  always_comb begin
    pending_d = pending_q;
    if (owner_d == owner_engine) begin
      pending_d = 1'b0;
    end else if (eng_start_i && owner_q != owner_engine) begin
      pending_d = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner_q   <= owner_none;
      pending_q <= 1'b0;
    end else begin
      owner_q   <= owner_d;
      pending_q <= pending_d;
    end
  end

  // remember who issued the last read so late data reaches the right master
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_sel_q <= owner_none;
    end else if (sram_req_o.cs && !sram_req_o.we) begin
      rd_sel_q <= (owner_q == owner_engine) ? owner_engine : owner_host;
    end
  end

  // host may still finish a transfer in the cycle the engine hands back
  always_comb begin
    sram_req_o = '0;
    if (owner_q == owner_engine) begin
      sram_req_o = eng_req_i;
    end else if (host_busy_i) begin
      sram_req_o = host_req_i;
    end
  end

  assign host_rdata_o  = (rd_sel_q == owner_host) ? sram_rdata : '0;
  assign eng_rdata_o   = (rd_sel_q == owner_engine) ? sram_rdata : '0;
  assign host_denied_o = host_busy_i && (owner_q == owner_engine);
  assign eng_grant_o   = (owner_q == owner_engine);

endmodule

// ==== rtl/apb_weight_port.sv ====
`timescale 1ns/100ps

module apb_weight_port #(
  parameter int word_addr_w = 10
) (
  input  logic                            clk,
  input  logic                            rst,
  input  wbuf_bus_pkg::apb_req_t          apb_req_i,
  output wbuf_bus_pkg::apb_rsp_t          apb_rsp_o,
  output wbuf_mem_pkg::mem_req_t          host_req_o,
  output logic                            host_busy_o,
  input  logic [wbuf_bus_pkg::data_w-1:0] host_rdata_i,
  input  logic                            host_denied_i
);

  import wbuf_bus_pkg::*;

  typedef enum logic [1:0] {
    ph_idle    = 2'd0,
    ph_access  = 2'd1,
    ph_rd_wait = 2'd2
  } port_phase_e;

  port_phase_e            phase_q, phase_d;
  logic [word_addr_w-1:0] word_idx;
  logic                   in_range;
  logic                   acc;
  logic                   err;

  // byte address to word index, upper bits must be clear
  assign word_idx = apb_req_i.paddr[word_addr_w+1:2];
  assign in_range = ~|apb_req_i.paddr[addr_w-1:word_addr_w+2];

  assign acc = (phase_q == ph_access) && apb_req_i.psel && apb_req_i.penable;
  assign err = !in_range || host_denied_i;

  // the host holds the buffer from setup until the completing cycle
  assign host_busy_o = apb_req_i.psel;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase_q <= ph_idle;
    end else begin
      phase_q <= phase_d;
    end
  end

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      ph_idle: begin
        if (apb_req_i.psel) begin
          phase_d = ph_access;
        end
      end
      ph_access: begin
        if (acc) begin
          // only a good read needs the extra cycle
          phase_d = (apb_req_i.pwrite || err) ? ph_idle : ph_rd_wait;
        end
      end
      ph_rd_wait: phase_d = ph_idle;
      default:    phase_d = ph_idle;
    endcase
  end

  // request goes out in the first access cycle only
  always_comb begin
    host_req_o                        = '0;
    host_req_o.cs                     = acc && !err;
    host_req_o.we                     = apb_req_i.pwrite;
    host_req_o.be                     = apb_req_i.pstrb;
    host_req_o.addr[word_addr_w-1:0]  = word_idx;
    host_req_o.wdata                  = apb_req_i.pwdata;
  end

  always_comb begin
    apb_rsp_o         = '0;
    apb_rsp_o.pready  = (acc && (apb_req_i.pwrite || err)) || (phase_q == ph_rd_wait);
    apb_rsp_o.pslverr = acc && err;
    if (phase_q == ph_rd_wait) begin
      apb_rsp_o.prdata = host_rdata_i;
    end
  end

endmodule

// ==== rtl/weight_sram.sv ====
`timescale 1ns/100ps

module weight_sram #(
  parameter int word_addr_w = 10
) (
  input  logic                            clk,
  input  logic                            rst,
  input  wbuf_mem_pkg::mem_req_t          mem_req_i,
  output logic [wbuf_bus_pkg::data_w-1:0] rdata_o
);

  import wbuf_bus_pkg::*;
  import wbuf_mem_pkg::*;

  localparam int depth = 1 << word_addr_w;

  logic [data_w-1:0]      mem_q [depth];
  logic [word_addr_w-1:0] idx;

  assign idx = mem_req_i.addr[word_addr_w-1:0];

  // byte-masked write, one lane per be bit
  always_ff @(posedge clk) begin
    if (mem_req_i.cs && mem_req_i.we) begin
      for (int b = 0; b < strb_w; b++) begin
        if (mem_req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdata_o <= '0;
    end else if (mem_req_i.cs && !mem_req_i.we) begin
      rdata_o <= mem_q[idx];
    end
  end

endmodule

// ==== rtl/wbuf_mem_pkg.sv ====
package wbuf_mem_pkg;

  // byte mask width of one SRAM word
  localparam int strb_w = wbuf_bus_pkg::data_w / 8;

  // full width of the word index field, the depth uses the low part
  localparam int mem_addr_w = 16;

  // chip-select request into the weight SRAM
  typedef struct packed {
    logic                            cs;
    logic                            we;
    logic [strb_w-1:0]               be;
    logic [mem_addr_w-1:0]           addr;
    logic [wbuf_bus_pkg::data_w-1:0] wdata;
  } mem_req_t;

  // which master currently holds the buffer
  typedef enum logic [1:0] {
    owner_none   = 2'd0,
    owner_host   = 2'd1,
    owner_engine = 2'd2
  } buf_owner_e;

endpackage

// ==== rtl/wbuf_bus_pkg.sv ====
package wbuf_bus_pkg;

  // one weight word
  localparam int data_w = 32;

  localparam int addr_w = 32;

  // one strobe bit per byte lane of a word
  localparam int pstrb_w = data_w / 8;

  // signals driven by the APB requester
  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [addr_w-1:0]  paddr;
    logic [data_w-1:0]  pwdata;
    logic [pstrb_w-1:0] pstrb;
  } apb_req_t;

  // signals returned by the APB completer
  typedef struct packed {
    logic              pready;
    logic              pslverr;
    logic [data_w-1:0] prdata;
  } apb_rsp_t;

endpackage
